// File: src/sample_disc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths and types shared by the sample discriminator stages
// samples are signed two's complement, delays count valid batches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package sample_disc_pkg;

  localparam int CHANNELS = 2;
  localparam int PARALLEL_SAMPLES = 4;
  localparam int SAMPLE_WIDTH = 16;
  localparam int MAX_DELAY = 16;
  // must be able to hold MAX_DELAY itself
  localparam int DELAY_WIDTH = $clog2(MAX_DELAY + 1);
  localparam int TIME_WIDTH = 24;
  localparam int INDEX_WIDTH = 8;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef sample_t [PARALLEL_SAMPLES-1:0] batch_t;

  typedef struct packed {
    sample_t                low_threshold;
    sample_t                high_threshold;
    logic [DELAY_WIDTH-1:0] pre_delay;
    logic [DELAY_WIDTH-1:0] post_delay;
    logic                   bypass;
  } channel_cfg_t;

  // record handed from one pipeline stage to the next
  typedef struct packed {
    logic   valid;
    batch_t batch;
    logic   trigger;
  } disc_stage_t;

  typedef struct packed {
    logic [TIME_WIDTH-1:0]  batch_time;
    logic [INDEX_WIDTH-1:0] segment_index;
  } tstamp_t;

  typedef enum logic {
    IDLE,
    HOLD
  } window_state_t;

endpackage

`default_nettype wire

// File: src/hysteresis_detector.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// arms above high_threshold, disarms when nothing exceeds low_threshold
// thresholds are compared signed and should satisfy low <= high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module hysteresis_detector #(
  parameter int PARALLEL_SAMPLES = sample_disc_pkg::PARALLEL_SAMPLES
) (
  input  logic                         adc_clk,
  input  logic                         adc_reset,
  input  logic                         valid_i,
  input  sample_disc_pkg::batch_t      batch_i,
  input  sample_disc_pkg::sample_t     low_threshold_i,
  input  sample_disc_pkg::sample_t     high_threshold_i,
  output sample_disc_pkg::disc_stage_t stage_o
);
  import sample_disc_pkg::*;

  logic   above_low;
  logic   above_high;
  logic   valid_q;
  logic   level_q;
  batch_t batch_q;

  // any sample of the batch strictly above each threshold
  always_comb begin
    above_low = 1'b0;
    above_high = 1'b0;
    for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
      above_low = above_low | (sample_t'(batch_i[s]) > low_threshold_i);
      above_high = above_high | (sample_t'(batch_i[s]) > high_threshold_i);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_q <= 1'b0;
      level_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
      // high wins, otherwise hold while something stays above low
      if (valid_i) begin
        level_q <= above_high | (above_low & level_q);
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (valid_i) begin
      batch_q <= batch_i;
    end
  end

  assign stage_o = '{valid: valid_q, batch: batch_q, trigger: level_q};

endmodule

`default_nettype wire

// File: src/pretrigger_delay_line.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// holds batches back by pre_delay_i valid strobes, pre_delay_i <= MAX_DELAY
// empty after reset, so the first pre_delay_i strobes give no output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pretrigger_delay_line #(
  parameter int MAX_DELAY = sample_disc_pkg::MAX_DELAY
) (
  input  logic                                    adc_clk,
  input  logic                                    adc_reset,
  input  logic [sample_disc_pkg::DELAY_WIDTH-1:0] pre_delay_i,
  input  sample_disc_pkg::disc_stage_t            stage_i,
  output sample_disc_pkg::disc_stage_t            stage_o
);
  import sample_disc_pkg::*;

  localparam int SEL_WIDTH = (MAX_DELAY > 1) ? $clog2(MAX_DELAY) : 1;

  // slot m holds the batch from m+1 strobes back, the input is tap 0
  logic [MAX_DELAY-1:0] occupied_q;
  batch_t               slot_batch_q [MAX_DELAY];
  logic [SEL_WIDTH-1:0] sel;
  logic                 tap_valid;
  batch_t               tap_batch;
  logic                 out_valid_q;
  batch_t               out_batch_q;
  logic                 out_trigger_q;

  assign sel = SEL_WIDTH'(pre_delay_i - 1'b1);

  always_comb begin
    if (pre_delay_i == '0) begin
      tap_valid = 1'b1;
      tap_batch = stage_i.batch;
    end else begin
      tap_valid = occupied_q[sel];
      tap_batch = slot_batch_q[sel];
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      occupied_q <= '0;
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= stage_i.valid & tap_valid;
      if (stage_i.valid) begin
        occupied_q[0] <= 1'b1;
        for (int m = 1; m < MAX_DELAY; m++) begin
          occupied_q[m] <= occupied_q[m-1];
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (stage_i.valid) begin
      slot_batch_q[0] <= stage_i.batch;
      for (int m = 1; m < MAX_DELAY; m++) begin
        slot_batch_q[m] <= slot_batch_q[m-1];
      end
      out_batch_q <= tap_batch;
      // undelayed trigger so it can reach back over the held batches
      out_trigger_q <= stage_i.trigger;
    end
  end

  assign stage_o = '{valid: out_valid_q, batch: out_batch_q, trigger: out_trigger_q};

endmodule

`default_nettype wire

// File: src/capture_window.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// marks delayed batches as kept, output trigger field means keep
// a trigger keeps pre_delay + post_delay further batches, bypass keeps all
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module capture_window (
  input  logic                                    adc_clk,
  input  logic                                    adc_reset,
  input  logic [sample_disc_pkg::DELAY_WIDTH-1:0] pre_delay_i,
  input  logic [sample_disc_pkg::DELAY_WIDTH-1:0] post_delay_i,
  input  logic                                    bypass_i,
  input  sample_disc_pkg::disc_stage_t            stage_i,
  output sample_disc_pkg::disc_stage_t            stage_o
);
  import sample_disc_pkg::*;

  window_state_t          state_q;
  logic [DELAY_WIDTH:0]   count_q;
  logic [DELAY_WIDTH:0]   span;
  logic                   keep;

  assign span = {1'b0, pre_delay_i} + {1'b0, post_delay_i};
  assign keep = stage_i.valid & (bypass_i | stage_i.trigger | (state_q == HOLD));

  assign stage_o = '{valid: stage_i.valid, batch: stage_i.batch, trigger: keep};

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      state_q <= IDLE;
      count_q <= '0;
    end else if (stage_i.valid) begin
      if (stage_i.trigger) begin
        // a new trigger restarts the window, so close windows merge
        count_q <= span;
        state_q <= (span != '0) ? HOLD : IDLE;
      end else if (state_q == HOLD) begin
        count_q <= count_q - 1'b1;
        if (count_q == 1) begin
          state_q <= IDLE;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/timestamp_tagger.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// batch time and segment index count from reset and wrap at their widths
// no timestamps are produced while bypass_i is set
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module timestamp_tagger (
  input  logic                         adc_clk,
  input  logic                         adc_reset,
  input  logic                         bypass_i,
  input  sample_disc_pkg::disc_stage_t stage_i,
  output logic                         samples_valid_o,
  output sample_disc_pkg::batch_t      samples_o,
  output logic                         tstamp_valid_o,
  output sample_disc_pkg::tstamp_t     tstamp_o
);
  import sample_disc_pkg::*;

  logic [TIME_WIDTH-1:0]  time_q;
  logic [INDEX_WIDTH-1:0] index_q;
  logic                   prev_kept_q;
  logic                   kept;
  logic                   seg_start;

  assign kept = stage_i.valid & stage_i.trigger;
  // first kept batch after a dropped one (or after reset)
  assign seg_start = kept & ~prev_kept_q & ~bypass_i;

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      time_q <= '0;
      index_q <= '0;
      prev_kept_q <= 1'b0;
      samples_valid_o <= 1'b0;
      tstamp_valid_o <= 1'b0;
    end else begin
      samples_valid_o <= kept;
      tstamp_valid_o <= seg_start;
      if (stage_i.valid) begin
        time_q <= time_q + 1'b1;
        prev_kept_q <= stage_i.trigger;
        if (stage_i.trigger) begin
          index_q <= index_q + 1'b1;
        end
      end
    end
  end

  // counters are sampled before this batch is counted
  always_ff @(posedge adc_clk) begin
    if (kept) begin
      samples_o <= stage_i.batch;
    end
    if (seg_start) begin
      tstamp_o <= '{batch_time: time_q, segment_index: index_q};
    end
  end

endmodule

`default_nettype wire

// File: src/discriminator_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one channel: detector, delay line, capture window, tagger
// cfg_i is static after reset, a pre_delay above MAX_DELAY is clamped
// triggers of the first pre_delay batches after reset are not counted
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module discriminator_channel #(
  parameter int MAX_DELAY = sample_disc_pkg::MAX_DELAY,
  parameter int PARALLEL_SAMPLES = sample_disc_pkg::PARALLEL_SAMPLES
) (
  input  logic                          adc_clk,
  input  logic                          adc_reset,
  input  logic                          valid_i,
  input  sample_disc_pkg::batch_t       batch_i,
  input  sample_disc_pkg::channel_cfg_t cfg_i,
  output logic                          samples_valid_o,
  output sample_disc_pkg::batch_t       samples_o,
  output logic                          tstamp_valid_o,
  output sample_disc_pkg::tstamp_t      tstamp_o
);
  import sample_disc_pkg::*;

  disc_stage_t            detect_stage;
  disc_stage_t            delay_stage;
  disc_stage_t            window_stage;
  logic [DELAY_WIDTH-1:0] pre_delay;

  // the delay line has no tap past MAX_DELAY
  assign pre_delay = (cfg_i.pre_delay > DELAY_WIDTH'(MAX_DELAY))
                   ? DELAY_WIDTH'(MAX_DELAY) : cfg_i.pre_delay;

  hysteresis_detector #(
    .PARALLEL_SAMPLES(PARALLEL_SAMPLES)
  ) hysteresis_detector_inst (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .valid_i(valid_i),
    .batch_i(batch_i),
    .low_threshold_i(cfg_i.low_threshold),
    .high_threshold_i(cfg_i.high_threshold),
    .stage_o(detect_stage)
  );

  pretrigger_delay_line #(
    .MAX_DELAY(MAX_DELAY)
  ) pretrigger_delay_line_inst (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .pre_delay_i(pre_delay),
    .stage_i(detect_stage),
    .stage_o(delay_stage)
  );

  capture_window capture_window_inst (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .pre_delay_i(pre_delay),
    .post_delay_i(cfg_i.post_delay),
    .bypass_i(cfg_i.bypass),
    .stage_i(delay_stage),
    .stage_o(window_stage)
  );

  timestamp_tagger timestamp_tagger_inst (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .bypass_i(cfg_i.bypass),
    .stage_i(window_stage),
    .samples_valid_o(samples_valid_o),
    .samples_o(samples_o),
    .tstamp_valid_o(tstamp_valid_o),
    .tstamp_o(tstamp_o)
  );

endmodule

`default_nettype wire

// File: src/sample_discriminator_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// independent discriminator per ADC channel, no back-pressure on outputs
// cfg_i is sampled during adc_reset and must stay steady afterwards
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sample_discriminator_top #(
  parameter int CHANNELS = sample_disc_pkg::CHANNELS,
  parameter int MAX_DELAY = sample_disc_pkg::MAX_DELAY,
  parameter int PARALLEL_SAMPLES = sample_disc_pkg::PARALLEL_SAMPLES
) (
  input  logic                                         adc_clk,
  input  logic                                         adc_reset,
  input  logic [CHANNELS-1:0]                          adc_valid_i,
  input  sample_disc_pkg::batch_t [CHANNELS-1:0]       adc_batch_i,
  input  sample_disc_pkg::channel_cfg_t [CHANNELS-1:0] cfg_i,
  output logic [CHANNELS-1:0]                          samples_valid_o,
  output sample_disc_pkg::batch_t [CHANNELS-1:0]       samples_o,
  output logic [CHANNELS-1:0]                          tstamp_valid_o,
  output sample_disc_pkg::tstamp_t [CHANNELS-1:0]      tstamp_o
);

  // every channel triggers on its own data only
  for (genvar c = 0; c < CHANNELS; c++) begin : g_channel
    discriminator_channel #(
      .MAX_DELAY(MAX_DELAY),
      .PARALLEL_SAMPLES(PARALLEL_SAMPLES)
    ) discriminator_channel_inst (
      .adc_clk(adc_clk),
      .adc_reset(adc_reset),
      .valid_i(adc_valid_i[c]),
      .batch_i(adc_batch_i[c]),
      .cfg_i(cfg_i[c]),
      .samples_valid_o(samples_valid_o[c]),
      .samples_o(samples_o[c]),
      .tstamp_valid_o(tstamp_valid_o[c]),
      .tstamp_o(tstamp_o[c])
    );
  end

endmodule

`default_nettype wire

// File: tb/disc_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model of keep decisions and timestamps, plus xorshift source
// included inside the testbench module, works on its recorded input arrays
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DISC_MODEL_SVH
`define DISC_MODEL_SVH

logic model_level [MAX_REC];

// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] next_random();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// true when some sample is strictly above thr, signed
function automatic logic any_above(batch_t b, sample_t thr);
  logic    hit;
  sample_t v;
  hit = 1'b0;
  for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
    v = b[s];
    if (v > thr) begin
      hit = 1'b1;
    end
  end
  return hit;
endfunction

function automatic void build_model(int c);
  int   n;
  int   pre;
  int   post;
  int   k_lo;
  logic level;
  logic keep;
  logic prev_keep;
  n = in_count[c];
  pre = int'(cfg[c].pre_delay);
  post = int'(cfg[c].post_delay);
  level = 1'b0;
  for (int k = 0; k < n; k++) begin
    level = any_above(in_batch[c][k], cfg[c].high_threshold)
          | (any_above(in_batch[c][k], cfg[c].low_threshold) & level);
    model_level[k] = level;
  end
  exp_count[c] = 0;
  exp_ts_count[c] = 0;
  prev_keep = 1'b0;
  // the last pre batches stay inside the delay line
  for (int j = 0; j < n - pre; j++) begin
    keep = cfg[c].bypass;
    // triggers of the first pre batches never reach the window
    k_lo = (j - post > pre) ? j - post : pre;
    for (int k = k_lo; k <= j + pre; k++) begin
      keep = keep | model_level[k];
    end
    if (keep) begin
      if (!prev_keep && !cfg[c].bypass) begin
        exp_ts[c][exp_ts_count[c]] = '{batch_time: TIME_WIDTH'(j),
                                       segment_index: INDEX_WIDTH'(exp_count[c])};
        exp_ts_pos[c][exp_ts_count[c]] = exp_count[c];
        exp_ts_count[c]++;
      end
      exp_batch[c][exp_count[c]] = in_batch[c][j];
      exp_count[c]++;
    end
    prev_keep = keep;
  end
endfunction

`endif

// File: tb/sample_discriminator_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random batches and valid gaps, seed 86, checked against disc_model.svh
// each test resets the DUT, so batch time and segment index restart at 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sample_discriminator_tb;
  import sample_disc_pkg::*;

  localparam logic [31:0] SEED = 32'd86;
  localparam int MAX_REC = 512;
  localparam int RESET_CYCLES = 4;
  localparam int PIPE_DEPTH = 4;
  localparam int BYPASS_CYCLES = 60;
  localparam int HYST_CYCLES = 200;
  localparam int PRE_CYCLES = 200;
  localparam int POST_CYCLES = 200;
  localparam int DUAL_CYCLES = 300;
  localparam int TEST_OVERHEAD = 2 + RESET_CYCLES + MAX_DELAY + 1 + 2 * PIPE_DEPTH;
  localparam int STIM_CYCLES = BYPASS_CYCLES + HYST_CYCLES + PRE_CYCLES + POST_CYCLES
                             + DUAL_CYCLES + 5 * TEST_OVERHEAD;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  logic                            adc_clk = 1'b0;
  logic                            adc_reset;
  logic [CHANNELS-1:0]             adc_valid;
  batch_t [CHANNELS-1:0]           adc_batch;
  channel_cfg_t [CHANNELS-1:0]     cfg;
  logic [CHANNELS-1:0]             samples_valid_o;
  batch_t [CHANNELS-1:0]           samples_o;
  logic [CHANNELS-1:0]             tstamp_valid_o;
  tstamp_t [CHANNELS-1:0]          tstamp_o;

  logic [31:0] rng_state;
  int          cycle_count = 0;
  string       test_name = "startup";

  // recorded stimulus and responses, per channel
  batch_t  in_batch [CHANNELS][MAX_REC];
  int      in_count [CHANNELS];
  batch_t  out_batch [CHANNELS][MAX_REC];
  int      out_count [CHANNELS];
  tstamp_t out_ts [CHANNELS][MAX_REC];
  int      out_ts_pos [CHANNELS][MAX_REC];
  int      out_ts_count [CHANNELS];

  // model results
  batch_t  exp_batch [CHANNELS][MAX_REC];
  int      exp_count [CHANNELS];
  tstamp_t exp_ts [CHANNELS][MAX_REC];
  int      exp_ts_pos [CHANNELS][MAX_REC];
  int      exp_ts_count [CHANNELS];

  `include "disc_model.svh"

  sample_discriminator_top #(
    .CHANNELS(CHANNELS),
    .MAX_DELAY(MAX_DELAY),
    .PARALLEL_SAMPLES(PARALLEL_SAMPLES)
  ) sample_discriminator_top_inst (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .adc_valid_i(adc_valid),
    .adc_batch_i(adc_batch),
    .cfg_i(cfg),
    .samples_valid_o(samples_valid_o),
    .samples_o(samples_o),
    .tstamp_valid_o(tstamp_valid_o),
    .tstamp_o(tstamp_o)
  );

  always #50 adc_clk = ~adc_clk;

  task automatic report_failure(string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(string what, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, expected, actual);
      report_failure("output does not match the model");
    end
  endtask

  always @(posedge adc_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("timeout in test %s after %0d cycles", test_name, cycle_count));
    end
  end

  // sample outputs on the edge, timestamp first so it records its sample position
  always @(posedge adc_clk) begin
    for (int c = 0; c < CHANNELS; c++) begin
      if (tstamp_valid_o[c] === 1'b1) begin
        if (out_ts_count[c] >= MAX_REC) begin
          report_failure($sformatf("too many timestamps on channel %0d", c));
        end else if (samples_valid_o[c] !== 1'b1) begin
          report_failure($sformatf("timestamp without its first batch on channel %0d", c));
        end else begin
          out_ts[c][out_ts_count[c]] = tstamp_o[c];
          out_ts_pos[c][out_ts_count[c]] = out_count[c];
          out_ts_count[c]++;
        end
      end
      if (samples_valid_o[c] === 1'b1) begin
        if (out_count[c] >= MAX_REC) begin
          report_failure($sformatf("too many output batches on channel %0d", c));
        end else begin
          out_batch[c][out_count[c]] = samples_o[c];
          out_count[c]++;
        end
      end
    end
  end

  function automatic channel_cfg_t make_cfg(int low, int high, int pre, int post, logic bypass);
    channel_cfg_t v;
    v.low_threshold = sample_t'(low);
    v.high_threshold = sample_t'(high);
    v.pre_delay = DELAY_WIDTH'(pre);
    v.post_delay = DELAY_WIDTH'(post);
    v.bypass = bypass;
    return v;
  endfunction

  // samples in -1024..1023 so both thresholds are straddled
  function automatic batch_t random_batch();
    batch_t      b;
    logic [31:0] r;
    for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
      r = next_random();
      b[s] = sample_t'($signed(r[10:0]));
    end
    return b;
  endfunction

  task automatic record_input(int c);
    if (in_count[c] >= MAX_REC) begin
      report_failure($sformatf("too many input batches on channel %0d", c));
    end else begin
      in_batch[c][in_count[c]] = adc_batch[c];
      in_count[c]++;
    end
  endtask

  task automatic next_drive_point();
    @(posedge adc_clk);
    #10;
  endtask

  task automatic compare_channel(int c);
    check_equal($sformatf("ch%0d batch count", c), 64'(exp_count[c]), 64'(out_count[c]));
    for (int i = 0; i < exp_count[c]; i++) begin
      check_equal($sformatf("ch%0d batch %0d", c, i), 64'(exp_batch[c][i]),
                  64'(out_batch[c][i]));
    end
    check_equal($sformatf("ch%0d timestamp count", c), 64'(exp_ts_count[c]),
                64'(out_ts_count[c]));
    for (int i = 0; i < exp_ts_count[c]; i++) begin
      check_equal($sformatf("ch%0d timestamp %0d", c, i), 64'(exp_ts[c][i]), 64'(out_ts[c][i]));
      check_equal($sformatf("ch%0d timestamp %0d position", c, i), 64'(exp_ts_pos[c][i]),
                  64'(out_ts_pos[c][i]));
    end
  endtask

  task automatic run_test(string name, channel_cfg_t [CHANNELS-1:0] cfgs,
                          logic [CHANNELS-1:0] active, int cycles);
    logic [31:0] r;
    int          max_flush;
    test_name = name;
    next_drive_point();
    adc_reset = 1'b1;
    adc_valid = '0;
    cfg = cfgs;
    repeat (RESET_CYCLES) next_drive_point();
    for (int c = 0; c < CHANNELS; c++) begin
      in_count[c] = 0;
      out_count[c] = 0;
      out_ts_count[c] = 0;
    end
    adc_reset = 1'b0;
    for (int t = 0; t < cycles; t++) begin
      for (int c = 0; c < CHANNELS; c++) begin
        r = next_random();
        adc_valid[c] = active[c] & (r[1:0] != 2'b00);
        adc_batch[c] = random_batch();
        if (adc_valid[c]) begin
          record_input(c);
        end
      end
      next_drive_point();
    end
    // push the held batches out of the delay line
    max_flush = 0;
    for (int c = 0; c < CHANNELS; c++) begin
      if (active[c] && int'(cfgs[c].pre_delay) + 1 > max_flush) begin
        max_flush = int'(cfgs[c].pre_delay) + 1;
      end
    end
    for (int f = 0; f < max_flush; f++) begin
      for (int c = 0; c < CHANNELS; c++) begin
        adc_valid[c] = active[c] & (f <= int'(cfgs[c].pre_delay));
        adc_batch[c] = '0;
        if (adc_valid[c]) begin
          record_input(c);
        end
      end
      next_drive_point();
    end
    adc_valid = '0;
    for (int c = 0; c < CHANNELS; c++) begin
      build_model(c);
      while (out_count[c] < exp_count[c]) begin
        next_drive_point();
      end
    end
    repeat (PIPE_DEPTH) next_drive_point();
    for (int c = 0; c < CHANNELS; c++) begin
      compare_channel(c);
    end
  endtask

  initial begin
    rng_state = SEED;
    adc_reset = 1'b1;
    adc_valid = '0;
    adc_batch = '0;
    cfg = '0;
    for (int c = 0; c < CHANNELS; c++) begin
      in_count[c] = 0;
      out_count[c] = 0;
      out_ts_count[c] = 0;
    end
    run_test("bypass", {make_cfg(0, 0, 0, 0, 1'b0), make_cfg(300, 900, 2, 1, 1'b1)},
             2'b01, BYPASS_CYCLES);
    run_test("hysteresis", {make_cfg(0, 0, 0, 0, 1'b0), make_cfg(300, 900, 0, 0, 1'b0)},
             2'b01, HYST_CYCLES);
    run_test("pre_trigger", {make_cfg(0, 0, 0, 0, 1'b0), make_cfg(300, 900, 5, 0, 1'b0)},
             2'b01, PRE_CYCLES);
    run_test("post_trigger", {make_cfg(0, 0, 0, 0, 1'b0), make_cfg(300, 900, 0, 6, 1'b0)},
             2'b01, POST_CYCLES);
    // negative low threshold on channel 1 checks the signed compare
    run_test("dual_channel", {make_cfg(-100, 950, 7, 2, 1'b0), make_cfg(300, 900, 3, 4, 1'b0)},
             2'b11, DUAL_CYCLES);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+tb
src/sample_disc_pkg.sv
src/hysteresis_detector.sv
src/pretrigger_delay_line.sv
src/capture_window.sv
src/timestamp_tagger.sv
src/discriminator_channel.sv
src/sample_discriminator_top.sv
tb/sample_discriminator_tb.sv

// File: Makefile
# Verilator build for the sample discriminator
# variables can be overridden, e.g. make sim OBJ_DIR=build

VERILATOR  ?= verilator
FILELIST   ?= sources.f
TB_TOP     ?= sample_discriminator_tb
RTL_TOP    ?= sample_discriminator_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

# the binary exits non-zero on $$fatal, so make fails with the test
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
